//--- axil_monitor.f
+incdir+design
design/axil_mon_pkg.sv
design/axil_outstanding.sv
design/axil_stability.sv
design/axil_timeouts.sv
design/axil_monitor.sv
dv/tb_clk_gen.sv
dv/tb_axil_monitor.sv

//--- design/axil_mon_params.svh
// AXI-lite monitor parameters
// Bus widths, counter depth and timer limits shared by every block

`ifndef AXIL_MON_PARAMS_SVH
`define AXIL_MON_PARAMS_SVH

// Bus widths
`define AXIL_ADDR_W 28
`define AXIL_DATA_W 32

// Bits per outstanding counter, all ones is an overflow
`define AXIL_LGDEPTH 4

// Cycles a request may wait for ready
`define AXIL_MAXWAIT 12
// Cycles a response may wait for its ready
`define AXIL_MAXRSTALL 12
// Cycles from accepted request to response
`define AXIL_MAXDELAY 12

// Width of every timer, holds all of the limits above
`define AXIL_LGTIMEOUT 4

`endif

//--- design/axil_mon_pkg.sv
// AXI-lite monitor types
// Channel structs, response codes and the violation flag set

`include "axil_mon_params.svh"

package axil_mon_pkg;

	// AXI response codes
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_e;

	//////////////////////////////
	// Channel views, valid and ready both observed
	//////////////////////////////

	typedef struct packed
	{
		logic                      valid;
		logic                      ready;
		logic [`AXIL_ADDR_W-1:0]   addr;
	} axil_aw_t;

	typedef struct packed
	{
		logic                      valid;
		logic                      ready;
		logic [`AXIL_DATA_W-1:0]   data;
		logic [`AXIL_DATA_W/8-1:0] strb;
	} axil_w_t;

	typedef struct packed
	{
		logic       valid;
		logic       ready;
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed
	{
		logic                      valid;
		logic                      ready;
		logic [`AXIL_ADDR_W-1:0]   addr;
	} axil_ar_t;

	typedef struct packed
	{
		logic                      valid;
		logic                      ready;
		axil_resp_e                resp;
		logic [`AXIL_DATA_W-1:0]   data;
	} axil_r_t;

	// Outstanding transfer counts
	typedef struct packed
	{
		logic [`AXIL_LGDEPTH-1:0] aw;
		logic [`AXIL_LGDEPTH-1:0] w;
		logic [`AXIL_LGDEPTH-1:0] rd;
	} axil_cnt_t;

	// Sticky violation flags, cleared only by reset
	typedef struct packed
	{
		logic valid_after_reset;
		logic unstable_req;
		logic unstable_resp;
		logic bad_resp;
		logic resp_without_req;
		logic count_overflow;
		logic req_stall;
		logic resp_stall;
		logic wr_delay;
		logic rd_delay;
	} axil_viol_t;

endpackage

//--- design/axil_monitor.sv
// AXI-lite protocol monitor top
// Passive on all five channels, gathers the checker flags into one violation set

`timescale 1ns/100ps

`include "axil_mon_params.svh"

module axil_monitor
	import axil_mon_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_axi_reset_n,
	input  axil_aw_t   i_aw,
	input  axil_w_t    i_w,
	input  axil_b_t    i_b,
	input  axil_ar_t   i_ar,
	input  axil_r_t    i_r,
	output axil_cnt_t  o_cnt,
	output axil_viol_t o_viol
);

	// Checker flags
	logic overflow;
	logic resp_without_req;
	logic valid_after_reset;
	logic unstable_req;
	logic unstable_resp;
	logic bad_resp;
	logic req_stall;
	logic resp_stall;
	logic wr_delay;
	logic rd_delay;

	//////////////////////////////
	// Checkers
	//////////////////////////////

	// Counts also feed the timers
	axil_outstanding u_outstanding (
		.i_clk              (i_clk),
		.i_axi_reset_n      (i_axi_reset_n),
		.i_aw               (i_aw),
		.i_w                (i_w),
		.i_b                (i_b),
		.i_ar               (i_ar),
		.i_r                (i_r),
		.o_cnt              (o_cnt),
		.o_overflow         (overflow),
		.o_resp_without_req (resp_without_req)
	);

	axil_stability u_stability (
		.i_clk               (i_clk),
		.i_axi_reset_n       (i_axi_reset_n),
		.i_aw                (i_aw),
		.i_w                 (i_w),
		.i_b                 (i_b),
		.i_ar                (i_ar),
		.i_r                 (i_r),
		.o_valid_after_reset (valid_after_reset),
		.o_unstable_req      (unstable_req),
		.o_unstable_resp     (unstable_resp),
		.o_bad_resp          (bad_resp)
	);

	axil_timeouts u_timeouts (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_aw          (i_aw),
		.i_w           (i_w),
		.i_b           (i_b),
		.i_ar          (i_ar),
		.i_r           (i_r),
		.i_cnt         (o_cnt),
		.o_req_stall   (req_stall),
		.o_resp_stall  (resp_stall),
		.o_wr_delay    (wr_delay),
		.o_rd_delay    (rd_delay)
	);

	assign o_viol = '{
		valid_after_reset: valid_after_reset,
		unstable_req:      unstable_req,
		unstable_resp:     unstable_resp,
		bad_resp:          bad_resp,
		resp_without_req:  resp_without_req,
		count_overflow:    overflow,
		req_stall:         req_stall,
		resp_stall:        resp_stall,
		wr_delay:          wr_delay,
		rd_delay:          rd_delay
	};

endmodule

//--- design/axil_outstanding.sv
// AXI-lite outstanding transfer counters
// Tracks write address, write data and read depth, flags overflow and orphan responses

`timescale 1ns/100ps

`include "axil_mon_params.svh"

module axil_outstanding
	import axil_mon_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_axi_reset_n,
	input  axil_aw_t  i_aw,
	input  axil_w_t   i_w,
	input  axil_b_t   i_b,
	input  axil_ar_t  i_ar,
	input  axil_r_t   i_r,
	output axil_cnt_t o_cnt,
	output logic      o_overflow,
	output logic      o_resp_without_req
);

	// Transfers seen this cycle
	logic aw_req;
	logic w_req;
	logic ar_req;
	logic b_ack;
	logic r_ack;

	logic [`AXIL_LGDEPTH-1:0] aw_cnt;
	logic [`AXIL_LGDEPTH-1:0] w_cnt;
	logic [`AXIL_LGDEPTH-1:0] rd_cnt;

	assign aw_req = i_aw.valid && i_aw.ready;
	assign w_req  = i_w.valid && i_w.ready;
	assign ar_req = i_ar.valid && i_ar.ready;
	assign b_ack  = i_b.valid && i_b.ready;
	assign r_ack  = i_r.valid && i_r.ready;

	// Up on request, down on response, hold when both land together
	function automatic logic [`AXIL_LGDEPTH-1:0] cnt_next(
		input logic [`AXIL_LGDEPTH-1:0] cur,
		input logic                     up,
		input logic                     down
	);
		case ({up, down})
			2'b10:   return cur + 1'b1;
			2'b01:   return cur - 1'b1;
			default: return cur;
		endcase
	endfunction

	//////////////////////////////
	// Counters
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_cnt <= '0;
			w_cnt  <= '0;
			rd_cnt <= '0;
		end
		else
		begin
			aw_cnt <= cnt_next(aw_cnt, aw_req, b_ack);
			// Write data retires on the same response as its address
			w_cnt  <= cnt_next(w_cnt, w_req, b_ack);
			rd_cnt <= cnt_next(rd_cnt, ar_req, r_ack);
		end
	end

	assign o_cnt = '{aw: aw_cnt, w: w_cnt, rd: rd_cnt};

	//////////////////////////////
	// Sticky flags
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_overflow         <= 1'b0;
			o_resp_without_req <= 1'b0;
		end
		else
		begin
			// All ones means the next request would wrap
			if ((&aw_cnt) || (&w_cnt) || (&rd_cnt))
				o_overflow <= 1'b1;
			// A write response needs both address and data pending
			if (i_b.valid && ((aw_cnt == '0) || (w_cnt == '0)))
				o_resp_without_req <= 1'b1;
			if (i_r.valid && (rd_cnt == '0))
				o_resp_without_req <= 1'b1;
		end
	end

	// An empty counter only wraps down through an orphan response, which is flagged
	a_no_silent_underflow: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		((($past(aw_cnt) == '0) && (&aw_cnt)) || (($past(w_cnt) == '0) && (&w_cnt))
			|| (($past(rd_cnt) == '0) && (&rd_cnt)))
		|-> o_resp_without_req);

endmodule

//--- design/axil_stability.sv
// AXI-lite handshake rule checker
// Flags valids right after reset, stalled transfers that change, and EXOKAY responses

`timescale 1ns/100ps

`include "axil_mon_params.svh"

module axil_stability
	import axil_mon_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_axi_reset_n,
	input  axil_aw_t i_aw,
	input  axil_w_t  i_w,
	input  axil_b_t  i_b,
	input  axil_ar_t i_ar,
	input  axil_r_t  i_r,
	output logic     o_valid_after_reset,
	output logic     o_unstable_req,
	output logic     o_unstable_resp,
	output logic     o_bad_resp
);

	// Reset level of the previous cycle
	logic rst_n_q;

	// Previous cycle held valid without ready
	logic aw_wait_q;
	logic w_wait_q;
	logic b_wait_q;
	logic ar_wait_q;
	logic r_wait_q;

	// Previous payloads
	logic [`AXIL_ADDR_W-1:0]   aw_addr_q;
	logic [`AXIL_DATA_W-1:0]   w_data_q;
	logic [`AXIL_DATA_W/8-1:0] w_strb_q;
	axil_resp_e                b_resp_q;
	logic [`AXIL_ADDR_W-1:0]   ar_addr_q;
	axil_resp_e                r_resp_q;
	logic [`AXIL_DATA_W-1:0]   r_data_q;

	logic any_valid;
	logic req_broken;
	logic resp_broken;
	logic exokay_seen;

	//////////////////////////////
	// Previous cycle capture
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		rst_n_q   <= i_axi_reset_n;
		aw_addr_q <= i_aw.addr;
		w_data_q  <= i_w.data;
		w_strb_q  <= i_w.strb;
		b_resp_q  <= i_b.resp;
		ar_addr_q <= i_ar.addr;
		r_resp_q  <= i_r.resp;
		r_data_q  <= i_r.data;
	end

	// Wait bits stay low through reset so no check runs on the first cycle out
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_wait_q <= 1'b0;
			w_wait_q  <= 1'b0;
			b_wait_q  <= 1'b0;
			ar_wait_q <= 1'b0;
			r_wait_q  <= 1'b0;
		end
		else
		begin
			aw_wait_q <= i_aw.valid && !i_aw.ready;
			w_wait_q  <= i_w.valid && !i_w.ready;
			b_wait_q  <= i_b.valid && !i_b.ready;
			ar_wait_q <= i_ar.valid && !i_ar.ready;
			r_wait_q  <= i_r.valid && !i_r.ready;
		end
	end

	//////////////////////////////
	// Rule checks
	//////////////////////////////

	assign any_valid = i_aw.valid || i_w.valid || i_b.valid || i_ar.valid || i_r.valid;

	// Stalled request dropped or changed
	assign req_broken = (aw_wait_q && (!i_aw.valid || (i_aw.addr != aw_addr_q)))
		|| (w_wait_q && (!i_w.valid || (i_w.data != w_data_q) || (i_w.strb != w_strb_q)))
		|| (ar_wait_q && (!i_ar.valid || (i_ar.addr != ar_addr_q)));

	// Stalled response dropped or changed
	assign resp_broken = (b_wait_q && (!i_b.valid || (i_b.resp != b_resp_q)))
		|| (r_wait_q && (!i_r.valid || (i_r.resp != r_resp_q) || (i_r.data != r_data_q)));

	// Exclusive access is not part of AXI-lite
	assign exokay_seen = (i_b.valid && (i_b.resp == EXOKAY))
		|| (i_r.valid && (i_r.resp == EXOKAY));

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_valid_after_reset <= 1'b0;
			o_unstable_req      <= 1'b0;
			o_unstable_resp     <= 1'b0;
			o_bad_resp          <= 1'b0;
		end
		else
		begin
			if (!rst_n_q && any_valid)
				o_valid_after_reset <= 1'b1;
			if (req_broken)
				o_unstable_req <= 1'b1;
			if (resp_broken)
				o_unstable_resp <= 1'b1;
			if (exokay_seen)
				o_bad_resp <= 1'b1;
		end
	end

	// First edge out of reset never raises a stability flag
	a_clear_after_reset: assert property (@(posedge i_clk)
		(!rst_n_q && i_axi_reset_n) |=> !(o_unstable_req || o_unstable_resp));

endmodule

//--- design/axil_timeouts.sv
// AXI-lite timing checker
// Seven saturating timers for request stalls, response stalls and response delays

`timescale 1ns/100ps

`include "axil_mon_params.svh"

module axil_timeouts
	import axil_mon_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_axi_reset_n,
	input  axil_aw_t  i_aw,
	input  axil_w_t   i_w,
	input  axil_b_t   i_b,
	input  axil_ar_t  i_ar,
	input  axil_r_t   i_r,
	input  axil_cnt_t i_cnt,
	output logic      o_req_stall,
	output logic      o_resp_stall,
	output logic      o_wr_delay,
	output logic      o_rd_delay
);

	// Limits sized to the timers
	localparam logic [`AXIL_LGTIMEOUT-1:0] MAXWAIT   = `AXIL_MAXWAIT;
	localparam logic [`AXIL_LGTIMEOUT-1:0] MAXRSTALL = `AXIL_MAXRSTALL;
	localparam logic [`AXIL_LGTIMEOUT-1:0] MAXDELAY  = `AXIL_MAXDELAY;

	// Conditions under which each timer runs
	logic aw_run;
	logic w_run;
	logic ar_run;
	logic b_run;
	logic r_run;
	logic wr_run;
	logic rd_run;

	logic [`AXIL_LGTIMEOUT-1:0] aw_tmr;
	logic [`AXIL_LGTIMEOUT-1:0] w_tmr;
	logic [`AXIL_LGTIMEOUT-1:0] ar_tmr;
	logic [`AXIL_LGTIMEOUT-1:0] b_tmr;
	logic [`AXIL_LGTIMEOUT-1:0] r_tmr;
	logic [`AXIL_LGTIMEOUT-1:0] wr_tmr;
	logic [`AXIL_LGTIMEOUT-1:0] rd_tmr;

	logic [3:0] flags;

	// Count while running, saturate at all ones, clear otherwise
	function automatic logic [`AXIL_LGTIMEOUT-1:0] tick(
		input logic [`AXIL_LGTIMEOUT-1:0] cur,
		input logic                       run
	);
		if (!run)
			return '0;
		else if (&cur)
			return cur;
		else
			return cur + 1'b1;
	endfunction

	//////////////////////////////
	// Request stalls
	//////////////////////////////

	// A pending response excuses the slave
	// so does waiting on the partner write channel when it is behind
	assign aw_run = i_aw.valid && !i_aw.ready && !i_b.valid
		&& !((i_cnt.aw >= i_cnt.w) && !i_w.valid);
	assign w_run = i_w.valid && !i_w.ready && !i_b.valid
		&& !((i_cnt.w >= i_cnt.aw) && !i_aw.valid);
	assign ar_run = i_ar.valid && !i_ar.ready && !i_r.valid;

	//////////////////////////////
	// Response stalls and delays
	//////////////////////////////

	assign b_run = i_b.valid && !i_b.ready;
	assign r_run = i_r.valid && !i_r.ready;

	// Write waits until both address and data are in
	assign wr_run = (i_cnt.aw != '0) && (i_cnt.w != '0) && !i_b.valid;
	assign rd_run = (i_cnt.rd != '0) && !i_r.valid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_tmr <= '0;
			w_tmr  <= '0;
			ar_tmr <= '0;
			b_tmr  <= '0;
			r_tmr  <= '0;
			wr_tmr <= '0;
			rd_tmr <= '0;
		end
		else
		begin
			aw_tmr <= tick(aw_tmr, aw_run);
			w_tmr  <= tick(w_tmr, w_run);
			ar_tmr <= tick(ar_tmr, ar_run);
			b_tmr  <= tick(b_tmr, b_run);
			r_tmr  <= tick(r_tmr, r_run);
			wr_tmr <= tick(wr_tmr, wr_run);
			rd_tmr <= tick(rd_tmr, rd_run);
		end
	end

	// Flags trail the timer by one cycle
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_req_stall  <= 1'b0;
			o_resp_stall <= 1'b0;
			o_wr_delay   <= 1'b0;
			o_rd_delay   <= 1'b0;
		end
		else
		begin
			if ((aw_tmr >= MAXWAIT) || (w_tmr >= MAXWAIT) || (ar_tmr >= MAXWAIT))
				o_req_stall <= 1'b1;
			if ((b_tmr >= MAXRSTALL) || (r_tmr >= MAXRSTALL))
				o_resp_stall <= 1'b1;
			if (wr_tmr >= MAXDELAY)
				o_wr_delay <= 1'b1;
			if (rd_tmr >= MAXDELAY)
				o_rd_delay <= 1'b1;
		end
	end

	assign flags = {o_req_stall, o_resp_stall, o_wr_delay, o_rd_delay};

	// No flag falls while out of reset
	a_flags_sticky: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(flags != '0) |=> ((flags & $past(flags)) == $past(flags)));

endmodule

//--- dv/tb_axil_monitor.sv
// AXI-lite monitor testbench
// Directed tests drive legal and illegal traffic, then check counts and flags

`timescale 1ns/100ps

`include "axil_mon_params.svh"

module tb_axil_monitor
	import axil_mon_pkg::*;
();

	// Whole suite takes a few hundred cycles
	localparam int MAX_CYCLES = 2000;
	// Counter value that trips the overflow flag
	localparam int DEPTH_MAX = (1 << `AXIL_LGDEPTH) - 1;

	logic       clk;
	logic       axi_reset_n;
	axil_aw_t   aw;
	axil_w_t    w;
	axil_b_t    b;
	axil_ar_t   ar;
	axil_r_t    r;
	axil_cnt_t  cnt;
	axil_viol_t viol;

	integer seed = 32'he357;
	int     error_count = 0;
	int     check_count = 0;
	int     cycle_count = 0;
	string  test_name = "init";

	tb_clk_gen u_clk_gen (
		.o_clk (clk)
	);

	axil_monitor uut (
		.i_clk         (clk),
		.i_axi_reset_n (axi_reset_n),
		.i_aw          (aw),
		.i_w           (w),
		.i_b           (b),
		.i_ar          (ar),
		.i_r           (r),
		.o_cnt         (cnt),
		.o_viol        (viol)
	);

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			error_count++;
			$display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [`AXIL_ADDR_W-1:0] random_addr();
		logic [31:0] value;
		value = next_random();
		return value[`AXIL_ADDR_W-1:0];
	endfunction

	// Inputs change 10 ns after the edge, outputs are settled by then
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic idle_bus();
		aw = '0;
		w  = '0;
		b  = '0;
		ar = '0;
		r  = '0;
	endtask

	// Four cycles in reset, returns with reset just released
	task automatic apply_reset();
		idle_bus();
		axi_reset_n = 1'b0;
		repeat (4)
			next_cycle();
		axi_reset_n = 1'b1;
	endtask

	// Reset plus one quiet cycle so valids are legal again
	task automatic begin_test(input string name);
		test_name = name;
		apply_reset();
		next_cycle();
	endtask

	task automatic check_value(
		input string       what,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic check_counts(input int exp_aw, input int exp_w, input int exp_rd);
		check_value("aw count", exp_aw, cnt.aw);
		check_value("w count", exp_w, cnt.w);
		check_value("rd count", exp_rd, cnt.rd);
	endtask

	// One read address accepted at once, leaves rd count at one
	task automatic accept_read_address();
		ar.valid = 1'b1;
		ar.ready = 1'b1;
		ar.addr  = random_addr();
		next_cycle();
		ar = '0;
	endtask

	// Address and data together, ready a cycle late, then OKAY
	task automatic write_once();
		logic [31:0] strb_src;
		strb_src = next_random();
		aw.valid = 1'b1;
		aw.addr  = random_addr();
		w.valid  = 1'b1;
		w.data   = next_random();
		w.strb   = strb_src[`AXIL_DATA_W/8-1:0];
		next_cycle();
		aw.ready = 1'b1;
		w.ready  = 1'b1;
		next_cycle();
		aw = '0;
		w  = '0;
		check_counts(1, 1, 0);
		check_value("o_viol", '0, viol);
		// Response waits one cycle for bready
		b.valid = 1'b1;
		b.resp  = OKAY;
		next_cycle();
		b.ready = 1'b1;
		next_cycle();
		b = '0;
		check_counts(0, 0, 0);
		check_value("o_viol", '0, viol);
	endtask

	task automatic read_once();
		ar.valid = 1'b1;
		ar.addr  = random_addr();
		next_cycle();
		ar.ready = 1'b1;
		next_cycle();
		ar = '0;
		check_counts(0, 0, 1);
		check_value("o_viol", '0, viol);
		r.valid = 1'b1;
		r.resp  = OKAY;
		r.data  = next_random();
		next_cycle();
		r.ready = 1'b1;
		next_cycle();
		r = '0;
		check_counts(0, 0, 0);
		check_value("o_viol", '0, viol);
	endtask

	// Called on cycle 0 of a stall, flag low at the limit, high one later
	task automatic expect_flag_at_limit(input int limit, input axil_viol_t flag);
		repeat (limit)
			next_cycle();
		check_value("o_viol at limit", '0, viol);
		next_cycle();
		check_value("o_viol past limit", flag, viol);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic clean_traffic();
		begin_test("clean traffic");
		check_counts(0, 0, 0);
		check_value("o_viol", '0, viol);
		write_once();
		write_once();
		read_once();
		read_once();
		check_counts(0, 0, 0);
		check_value("o_viol", '0, viol);
	endtask

	task automatic outstanding_depth();
		begin_test("outstanding depth");
		// Three back-to-back read addresses, no data yet
		for (int i = 0; i < 3; i++)
		begin
			ar.valid = 1'b1;
			ar.ready = 1'b1;
			ar.addr  = random_addr();
			next_cycle();
			check_counts(0, 0, i + 1);
		end
		ar = '0;
		for (int i = 0; i < 3; i++)
		begin
			r.valid = 1'b1;
			r.ready = 1'b1;
			r.resp  = OKAY;
			r.data  = next_random();
			next_cycle();
			check_counts(0, 0, 2 - i);
		end
		r = '0;
		// Address without its data
		aw.valid = 1'b1;
		aw.ready = 1'b1;
		aw.addr  = random_addr();
		next_cycle();
		aw = '0;
		check_counts(1, 0, 0);
		check_value("o_viol", '0, viol);
	endtask

	task automatic stability_and_reset();
		axil_viol_t exp_viol;
		// Valid on the first cycle out of reset
		test_name = "valid after reset";
		apply_reset();
		aw.valid = 1'b1;
		aw.addr  = random_addr();
		next_cycle();
		exp_viol = '0;
		exp_viol.valid_after_reset = 1'b1;
		check_value("o_viol", exp_viol, viol);

		begin_test("unstable request");
		aw.valid = 1'b1;
		aw.addr  = random_addr();
		next_cycle();
		check_value("o_viol", '0, viol);
		// Withdrawn before awready
		aw.valid = 1'b0;
		next_cycle();
		exp_viol = '0;
		exp_viol.unstable_req = 1'b1;
		check_value("o_viol", exp_viol, viol);

		begin_test("unstable response");
		accept_read_address();
		r.valid = 1'b1;
		r.resp  = OKAY;
		r.data  = next_random();
		next_cycle();
		check_value("o_viol", '0, viol);
		r.data = ~r.data;
		next_cycle();
		exp_viol = '0;
		exp_viol.unstable_resp = 1'b1;
		check_value("o_viol", exp_viol, viol);
	endtask

	task automatic response_rules();
		axil_viol_t exp_viol;
		// bready stays low so the counts never move
		begin_test("response without request");
		b.valid = 1'b1;
		b.resp  = OKAY;
		next_cycle();
		exp_viol = '0;
		exp_viol.resp_without_req = 1'b1;
		check_value("o_viol", exp_viol, viol);

		begin_test("exclusive okay");
		accept_read_address();
		r.valid = 1'b1;
		r.ready = 1'b1;
		r.resp  = EXOKAY;
		r.data  = next_random();
		next_cycle();
		r = '0;
		exp_viol = '0;
		exp_viol.bad_resp = 1'b1;
		check_value("o_viol", exp_viol, viol);

		begin_test("counter overflow");
		for (int i = 0; i < DEPTH_MAX; i++)
		begin
			ar.valid = 1'b1;
			ar.ready = 1'b1;
			ar.addr  = random_addr();
			next_cycle();
		end
		ar = '0;
		check_value("rd count", DEPTH_MAX, cnt.rd);
		check_value("count_overflow", 0, viol.count_overflow);
		next_cycle();
		check_value("count_overflow", 1, viol.count_overflow);
	endtask

	task automatic timer_limits();
		axil_viol_t exp_viol;
		begin_test("request stall");
		ar.valid = 1'b1;
		ar.addr  = random_addr();
		exp_viol = '0;
		exp_viol.req_stall = 1'b1;
		expect_flag_at_limit(`AXIL_MAXWAIT, exp_viol);

		begin_test("response stall");
		accept_read_address();
		r.valid = 1'b1;
		r.resp  = OKAY;
		r.data  = next_random();
		exp_viol = '0;
		exp_viol.resp_stall = 1'b1;
		expect_flag_at_limit(`AXIL_MAXRSTALL, exp_viol);

		// Delay counts from the first cycle with rd count nonzero
		begin_test("read delay");
		accept_read_address();
		exp_viol = '0;
		exp_viol.rd_delay = 1'b1;
		expect_flag_at_limit(`AXIL_MAXDELAY, exp_viol);

		begin_test("write delay");
		aw.valid = 1'b1;
		aw.ready = 1'b1;
		aw.addr  = random_addr();
		w.valid  = 1'b1;
		w.ready  = 1'b1;
		w.data   = next_random();
		w.strb   = '1;
		next_cycle();
		aw = '0;
		w  = '0;
		exp_viol = '0;
		exp_viol.wr_delay = 1'b1;
		expect_flag_at_limit(`AXIL_MAXDELAY, exp_viol);
	endtask

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial
	begin
		axi_reset_n = 1'b0;
		idle_bus();
		clean_traffic();
		outstanding_depth();
		stability_and_reset();
		response_rules();
		timer_limits();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock source
// Free-running clock, 100 ns period

`timescale 1ns/100ps

module tb_clk_gen
(
	output logic o_clk
);

	// Half of the 100 ns period
	localparam real HALF_PERIOD = 50.0;

	initial
	begin
		o_clk = 1'b0;
		forever
			#HALF_PERIOD o_clk = ~o_clk;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI-lite monitor testbench with Verilator
# Exit status is nonzero when the build, the run or any check fails

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_axil_monitor

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f axil_monitor.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q '>>> FAIL' "$LOG_FILE"; then
	echo "Simulation reported a failure, see $LOG_FILE"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
